/* Bender.yml */
package:
  name: conv_row

sources:
  - logic/conv_pkg.sv
  - logic/pixel_row_store.sv
  - logic/conv_row_ctrl.sv
  - logic/row_regs.sv
  - logic/window_shifter.sv
  - logic/conv_row_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/conv_row_tb.sv

/* logic/conv_pkg.sv */
package conv_pkg;

  ////////////////////////////////////////
  // pixel and segment geometry
  ////////////////////////////////////////

  // bits per pixel
  localparam int pix_w = 8;
  // pixels fetched per row for one segment
  localparam int seg_pixels = 32;
  // positions in each row register
  localparam int reg_bytes = 70;
  // pixels carried over from the segment to the left
  localparam int slab_max = 2;
  // taps in one 3x3 window
  localparam int win_taps = 9;

  // image store
  localparam int img_rows = 16;
  localparam int row_w = 4;
  localparam int img_segs = 2;
  localparam int seg_w = 1;

  // pad and slab counts, register indices
  localparam int pad_w = 4;
  localparam int idx_w = 16;

  // per byte op codes for the row registers
  localparam logic [1:0] op_hold = 2'd3;
  localparam logic [1:0] op_load = 2'd1;
  localparam logic [1:0] op_clear = 2'd0;

  // control FSM states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_fetch = 2'd1;
  localparam logic [1:0] st_stream = 2'd2;

  // sized forms of the geometry
  localparam logic [row_w-1:0] last_row = row_w'(img_rows - 1);
  localparam logic [pad_w-1:0] slab_full = pad_w'(slab_max);
  localparam logic [idx_w-1:0] seg_len = idx_w'(seg_pixels);

endpackage

/* logic/conv_row_ctrl.sv */
`timescale 1ns/1ps

module conv_row_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic cmd_start,
  input  logic [conv_pkg::row_w-1:0] cmd_row,
  input  logic [conv_pkg::seg_w-1:0] cmd_seg,
  input  logic [conv_pkg::pad_w-1:0] cmd_west_pad,
  input  logic [conv_pkg::pad_w-1:0] cmd_east_pad,
  input  logic row_end,
  output logic busy,
  output logic rd_en,
  output logic [conv_pkg::row_w-1:0] rd_row1,
  output logic [conv_pkg::row_w-1:0] rd_row2,
  output logic [conv_pkg::row_w-1:0] rd_row3,
  output logic [conv_pkg::seg_w-1:0] rd_seg,
  output logic row_valid1,
  output logic row_valid2,
  output logic row_valid3,
  output logic [conv_pkg::pad_w-1:0] west_pad,
  output logic [conv_pkg::pad_w-1:0] east_pad,
  output logic [conv_pkg::pad_w-1:0] slab_num,
  output logic [conv_pkg::idx_w-1:0] reg_start_idx,
  output logic [conv_pkg::idx_w-1:0] reg_end_idx,
  output logic fetch_done,
  output logic [conv_pkg::idx_w-1:0] fill_width
);

  logic [1:0] state;
  logic [conv_pkg::row_w-1:0] cmd_row_q;
  logic [conv_pkg::seg_w-1:0] cmd_seg_q;
  logic [conv_pkg::pad_w-1:0] west_q;
  logic [conv_pkg::pad_w-1:0] east_q;
  logic [conv_pkg::pad_w-1:0] slab_calc;

  // only segments after the first carry a slab
  assign slab_calc = (cmd_seg_q == '0) ? '0 : conv_pkg::slab_full;

  // busy from fetch issue until the last window
  assign busy = (state == conv_pkg::st_stream);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv_pkg::st_idle;
      rd_en <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      rd_en <= 1'b0;
      // store data is valid one cycle after the read
      fetch_done <= rd_en;
      case (state)
        conv_pkg::st_idle: begin
          if (cmd_start) begin
            state <= conv_pkg::st_fetch;
          end
        end
        conv_pkg::st_fetch: begin
          rd_en <= 1'b1;
          state <= conv_pkg::st_stream;
        end
        conv_pkg::st_stream: begin
          // cmd_start is dropped until here
          if (row_end) begin
            state <= conv_pkg::st_idle;
          end
        end
        default: state <= conv_pkg::st_idle;
      endcase
    end
  end

  // latch the accepted command
  always_ff @(posedge clk) begin
    if (state == conv_pkg::st_idle && cmd_start) begin
      cmd_row_q <= cmd_row;
      cmd_seg_q <= cmd_seg;
      west_q <= cmd_west_pad;
      east_q <= cmd_east_pad;
    end
  end

  ////////////////////////////////////////
  // row addresses and index window
  ////////////////////////////////////////

  // set once per command, stable while streaming
  always_ff @(posedge clk) begin
    if (state == conv_pkg::st_fetch) begin
      rd_row1 <= cmd_row_q - 1'b1;
      rd_row2 <= cmd_row_q;
      rd_row3 <= cmd_row_q + 1'b1;
      rd_seg <= cmd_seg_q;
      // rows outside the image load as zeros
      row_valid1 <= (cmd_row_q != '0);
      row_valid2 <= 1'b1;
      row_valid3 <= (cmd_row_q != conv_pkg::last_row);
      west_pad <= west_q;
      east_pad <= east_q;
      slab_num <= slab_calc;
      // first pixel sits after slab and west pad
      reg_start_idx <= slab_calc + west_q + 1'b1;
      reg_end_idx <= slab_calc + west_q + conv_pkg::seg_len;
      fill_width <= slab_calc + west_q + conv_pkg::seg_len + east_q;
    end
  end

endmodule

/* logic/conv_row_top.sv */
`timescale 1ns/1ps

module conv_row_top (
  input  logic clk,
  input  logic reset,
  input  logic img_we,
  input  logic [conv_pkg::row_w-1:0] img_row,
  input  logic [conv_pkg::seg_w-1:0] img_seg,
  input  logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] img_data,
  input  logic cmd_start,
  input  logic [conv_pkg::row_w-1:0] cmd_row,
  input  logic [conv_pkg::seg_w-1:0] cmd_seg,
  input  logic [conv_pkg::pad_w-1:0] cmd_west_pad,
  input  logic [conv_pkg::pad_w-1:0] cmd_east_pad,
  output logic busy,
  output logic win_valid,
  output logic [conv_pkg::win_taps*conv_pkg::pix_w-1:0] win_pixels,
  output logic row_end
);

  // store read side
  logic rd_en;
  logic [conv_pkg::row_w-1:0] rd_row1, rd_row2, rd_row3;
  logic [conv_pkg::seg_w-1:0] rd_seg;
  logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] row1_pixels, row2_pixels, row3_pixels;
  logic [conv_pkg::slab_max*conv_pkg::pix_w-1:0] row1_slab, row2_slab, row3_slab;

  // command fields for the reference block
  logic row_valid1, row_valid2, row_valid3;
  logic [conv_pkg::pad_w-1:0] west_pad, east_pad, slab_num;
  logic [conv_pkg::idx_w-1:0] reg_start_idx, reg_end_idx, fill_width;
  logic fetch_done;

  // loaded rows to the shifter
  logic [conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] row_regs_1, row_regs_2, row_regs_3;
  logic shift_start;

  pixel_row_store u_store (
    .clk, .reset, .img_we, .img_row, .img_seg, .img_data,
    .rd_en, .rd_row1, .rd_row2, .rd_row3, .rd_seg,
    .row1_pixels, .row2_pixels, .row3_pixels,
    .row1_slab, .row2_slab, .row3_slab
  );

  conv_row_ctrl u_ctrl (
    .clk, .reset, .cmd_start, .cmd_row, .cmd_seg, .cmd_west_pad, .cmd_east_pad,
    .row_end, .busy, .rd_en, .rd_row1, .rd_row2, .rd_row3, .rd_seg,
    .row_valid1, .row_valid2, .row_valid3, .west_pad, .east_pad, .slab_num,
    .reg_start_idx, .reg_end_idx, .fetch_done, .fill_width
  );

  row_regs u_row_regs (
    .clk, .reset, .fetch_done, .west_pad, .east_pad, .slab_num,
    .reg_start_idx, .reg_end_idx, .row_valid1, .row_valid2, .row_valid3,
    .row1_pixels, .row2_pixels, .row3_pixels, .row1_slab, .row2_slab, .row3_slab,
    .row_regs_1, .row_regs_2, .row_regs_3, .shift_start
  );

  window_shifter u_shifter (
    .clk, .reset, .shift_start, .fill_width,
    .row_regs_1, .row_regs_2, .row_regs_3,
    .win_valid, .row_end, .win_pixels
  );

endmodule

/* logic/pixel_row_store.sv */
`timescale 1ns/1ps

module pixel_row_store (
  input  logic clk,
  input  logic reset,
  input  logic img_we,
  input  logic [conv_pkg::row_w-1:0] img_row,
  input  logic [conv_pkg::seg_w-1:0] img_seg,
  input  logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] img_data,
  input  logic rd_en,
  input  logic [conv_pkg::row_w-1:0] rd_row1,
  input  logic [conv_pkg::row_w-1:0] rd_row2,
  input  logic [conv_pkg::row_w-1:0] rd_row3,
  input  logic [conv_pkg::seg_w-1:0] rd_seg,
  output logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] row1_pixels,
  output logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] row2_pixels,
  output logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] row3_pixels,
  output logic [conv_pkg::slab_max*conv_pkg::pix_w-1:0] row1_slab,
  output logic [conv_pkg::slab_max*conv_pkg::pix_w-1:0] row2_slab,
  output logic [conv_pkg::slab_max*conv_pkg::pix_w-1:0] row3_slab
);

  // one entry per row and segment, address is {row, seg}
  logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] mem [conv_pkg::img_rows*conv_pkg::img_segs];
  logic [2:0][conv_pkg::row_w-1:0] rd_rows;
  logic [2:0][conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] rd_pix_q;
  logic [2:0][conv_pkg::slab_max*conv_pkg::pix_w-1:0] rd_slab_q;

  assign rd_rows = {rd_row3, rd_row2, rd_row1};

  // single write port
  always_ff @(posedge clk) begin
    if (img_we) begin
      mem[{img_row, img_seg}] <= img_data;
    end
  end

  // three reads, one cycle latency
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pix_q <= '0;
      rd_slab_q <= '0;
    end else if (rd_en) begin
      for (int r = 0; r < 3; r++) begin
        rd_pix_q[r] <= mem[{rd_rows[r], rd_seg}];
        // segment 0 has no left neighbour
        if (rd_seg == '0) begin
          rd_slab_q[r] <= '0;
        end else begin
          // top two pixels of the left segment, pixel 30 low
          rd_slab_q[r] <= mem[{rd_rows[r], rd_seg - 1'b1}]
              [conv_pkg::seg_pixels*conv_pkg::pix_w-1 -: conv_pkg::slab_max*conv_pkg::pix_w];
        end
      end
    end
  end

  assign row1_pixels = rd_pix_q[0];
  assign row2_pixels = rd_pix_q[1];
  assign row3_pixels = rd_pix_q[2];
  assign row1_slab = rd_slab_q[0];
  assign row2_slab = rd_slab_q[1];
  assign row3_slab = rd_slab_q[2];

endmodule

/* logic/row_regs.sv */
`timescale 1ns/1ps

module row_regs (
  input  logic clk,
  input  logic reset,
  input  logic fetch_done,
  input  logic [conv_pkg::pad_w-1:0] west_pad,
  input  logic [conv_pkg::pad_w-1:0] east_pad,
  input  logic [conv_pkg::pad_w-1:0] slab_num,
  input  logic [conv_pkg::idx_w-1:0] reg_start_idx,
  input  logic [conv_pkg::idx_w-1:0] reg_end_idx,
  input  logic row_valid1,
  input  logic row_valid2,
  input  logic row_valid3,
  input  logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] row1_pixels,
  input  logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] row2_pixels,
  input  logic [conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] row3_pixels,
  input  logic [conv_pkg::slab_max*conv_pkg::pix_w-1:0] row1_slab,
  input  logic [conv_pkg::slab_max*conv_pkg::pix_w-1:0] row2_slab,
  input  logic [conv_pkg::slab_max*conv_pkg::pix_w-1:0] row3_slab,
  output logic [conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] row_regs_1,
  output logic [conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] row_regs_2,
  output logic [conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] row_regs_3,
  output logic shift_start
);

  // row indexed views of the ports
  logic [2:0][conv_pkg::seg_pixels*conv_pkg::pix_w-1:0] row_pix;
  logic [2:0][conv_pkg::slab_max*conv_pkg::pix_w-1:0] row_slab;
  logic [2:0] row_valid;

  // stage 1
  logic [2:0][conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] pix_s1;
  logic [2:0][conv_pkg::slab_max*conv_pkg::pix_w-1:0] slab_s1;
  logic [conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] end_mask_s1;
  logic [conv_pkg::idx_w-1:0] span_lo_s1;
  logic [conv_pkg::idx_w-1:0] span_hi_s1;
  logic [conv_pkg::pad_w-1:0] slab_num_s1;
  logic [2:0] valid_s1;
  logic fetch_s1;

  // stage 2
  logic [2:0][conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] slab_fill;
  logic [2:0][conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] fill_s2;
  logic [2:0][conv_pkg::reg_bytes-1:0][1:0] ops_s2;
  logic fetch_s2;

  // the row registers themselves
  logic [2:0][conv_pkg::reg_bytes-1:0][conv_pkg::pix_w-1:0] regs;

  assign row_pix = {row3_pixels, row2_pixels, row1_pixels};
  assign row_slab = {row3_slab, row2_slab, row1_slab};
  assign row_valid = {row_valid3, row_valid2, row_valid1};

  ////////////////////////////////////////
  // stage 1 shift and end mask
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      // pixel 0 lands at start index - 1
      pix_s1[r] <= {{((conv_pkg::reg_bytes - conv_pkg::seg_pixels) * conv_pkg::pix_w){1'b0}},
                    row_pix[r]} << (conv_pkg::pix_w * (reg_start_idx - 1'b1));
      slab_s1[r] <= row_slab[r];
    end
    // ones below the end index
    end_mask_s1 <= {(conv_pkg::reg_bytes * conv_pkg::pix_w){1'b1}}
                   >> (conv_pkg::pix_w * (conv_pkg::reg_bytes - reg_end_idx));
    // filled span covers slab, west pad, pixels and east pad
    span_lo_s1 <= reg_start_idx - slab_num - west_pad - 1'b1;
    span_hi_s1 <= reg_end_idx + east_pad;
    slab_num_s1 <= slab_num;
    valid_s1 <= row_valid;
  end

  // strobe pipeline alongside the data
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_s1 <= 1'b0;
      fetch_s2 <= 1'b0;
      shift_start <= 1'b0;
    end else begin
      fetch_s1 <= fetch_done;
      fetch_s2 <= fetch_s1;
      // registers are updated on the same edge
      shift_start <= fetch_s2;
    end
  end

  ////////////////////////////////////////
  // stage 2 mask, slab and op codes
  ////////////////////////////////////////

  // slab goes to the lowest positions
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      slab_fill[r] = '0;
      if (slab_num_s1 == conv_pkg::slab_full) begin
        slab_fill[r][conv_pkg::slab_max*conv_pkg::pix_w-1:0] = slab_s1[r];
      end else if (slab_num_s1 == 1) begin
        // single slab pixel is the rightmost one
        slab_fill[r][conv_pkg::pix_w-1:0] =
            slab_s1[r][conv_pkg::slab_max*conv_pkg::pix_w-1 -: conv_pkg::pix_w];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      fill_s2[r] <= (end_mask_s1 & pix_s1[r]) | slab_fill[r];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ops_s2 <= {(3 * conv_pkg::reg_bytes){conv_pkg::op_hold}};
    end else begin
      for (int r = 0; r < 3; r++) begin
        for (int i = 0; i < conv_pkg::reg_bytes; i++) begin
          if (!fetch_s1) begin
            ops_s2[r][i] <= conv_pkg::op_hold;
          end else if (valid_s1[r] && i >= span_lo_s1 && i < span_hi_s1) begin
            ops_s2[r][i] <= conv_pkg::op_load;
          end else begin
            // outside the span or an invalid row
            ops_s2[r][i] <= conv_pkg::op_clear;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // per byte load, clear or hold
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '0;
    end else begin
      for (int r = 0; r < 3; r++) begin
        for (int i = 0; i < conv_pkg::reg_bytes; i++) begin
          case (ops_s2[r][i])
            conv_pkg::op_load: regs[r][i] <= fill_s2[r][i*conv_pkg::pix_w +: conv_pkg::pix_w];
            conv_pkg::op_clear: regs[r][i] <= '0;
            default: regs[r][i] <= regs[r][i];
          endcase
        end
      end
    end
  end

  assign row_regs_1 = regs[0];
  assign row_regs_2 = regs[1];
  assign row_regs_3 = regs[2];

endmodule

/* logic/window_shifter.sv */
`timescale 1ns/1ps

module window_shifter (
  input  logic clk,
  input  logic reset,
  input  logic shift_start,
  input  logic [conv_pkg::idx_w-1:0] fill_width,
  input  logic [conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] row_regs_1,
  input  logic [conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] row_regs_2,
  input  logic [conv_pkg::reg_bytes*conv_pkg::pix_w-1:0] row_regs_3,
  output logic win_valid,
  output logic row_end,
  output logic [conv_pkg::win_taps*conv_pkg::pix_w-1:0] win_pixels
);

  logic [2:0][conv_pkg::reg_bytes-1:0][conv_pkg::pix_w-1:0] rows_q;
  logic [2:0][conv_pkg::reg_bytes-1:0][conv_pkg::pix_w-1:0] src_rows;
  logic [2:0][2:0][conv_pkg::pix_w-1:0] taps;
  logic [conv_pkg::idx_w-1:0] col;
  logic [conv_pkg::idx_w-1:0] src_col;
  logic [conv_pkg::idx_w-1:0] last_col;
  logic active;

  // first window comes straight from the fresh registers
  assign src_rows = shift_start ? {row_regs_3, row_regs_2, row_regs_1} : rows_q;
  assign src_col = shift_start ? '0 : col;

  // window k spans columns k..k+2
  assign last_col = fill_width - 2'd3;

  // top row in the low bytes
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      taps[r] = src_rows[r][src_col +: 3];
    end
  end

  ////////////////////////////////////////
  // window strobes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      win_valid <= 1'b0;
      row_end <= 1'b0;
    end else if (shift_start || active) begin
      win_valid <= 1'b1;
      row_end <= (src_col == last_col);
      active <= (src_col != last_col);
    end else begin
      win_valid <= 1'b0;
      row_end <= 1'b0;
    end
  end

  // column walk and captured rows
  always_ff @(posedge clk) begin
    if (shift_start) begin
      rows_q <= src_rows;
    end
    if (shift_start || active) begin
      col <= src_col + 1'b1;
      win_pixels <= taps;
    end
  end

endmodule

/* tb.f */
+incdir+tests
logic/conv_pkg.sv
logic/pixel_row_store.sv
logic/conv_row_ctrl.sv
logic/row_regs.sv
logic/window_shifter.sv
logic/conv_row_top.sv
tests/conv_row_tb.sv

/* tests/conv_row_cases.svh */
`ifndef conv_row_cases_svh
`define conv_row_cases_svh

// command table, one entry per line, one hex digit per column
// columns: centre row, segment, west pad, east pad, extra command while busy
localparam int num_cases = 12;

localparam logic [0:num_cases-1][19:0] case_tab = {
  // interior rows, plain segment 0 and the slab segment
  20'h5_0_0_0_1,
  20'h5_1_0_0_0,
  // widest pads on both sides
  20'h8_0_4_4_0,
  20'h8_1_4_4_1,
  // uneven pads
  20'h3_0_2_1_0,
  20'hb_1_1_3_0,
  // top edge, row above loads as zeros
  20'h0_0_1_1_0,
  20'h0_1_0_2_1,
  // bottom edge, row below loads as zeros
  20'hf_0_3_0_1,
  20'hf_1_4_4_0,
  // next to the edges
  20'h1_1_0_4_0,
  20'he_0_4_0_0
};

`endif

/* tests/conv_row_tb.sv */
`timescale 1ns/1ps

module conv_row_tb;

  `include "conv_row_cases.svh"

  localparam int row_bits = conv_pkg::seg_pixels * conv_pkg::pix_w;
  localparam int win_bits = conv_pkg::win_taps * conv_pkg::pix_w;
  // table entries, then reset and image load on top
  localparam int watchdog_cycles =
      num_cases * 100 + 10 + conv_pkg::img_rows * conv_pkg::img_segs + 10;

  logic clk;
  logic reset;
  logic img_we;
  logic [conv_pkg::row_w-1:0] img_row;
  logic [conv_pkg::seg_w-1:0] img_seg;
  logic [row_bits-1:0] img_data;
  logic cmd_start;
  logic [conv_pkg::row_w-1:0] cmd_row;
  logic [conv_pkg::seg_w-1:0] cmd_seg;
  logic [conv_pkg::pad_w-1:0] cmd_west_pad;
  logic [conv_pkg::pad_w-1:0] cmd_east_pad;
  logic busy;
  logic win_valid;
  logic [win_bits-1:0] win_pixels;
  logic row_end;

  integer seed = 75264;
  // copy of the image as written to the store
  logic [conv_pkg::pix_w-1:0] img_mem [conv_pkg::img_rows][conv_pkg::img_segs]
      [conv_pkg::seg_pixels];
  // expected row registers for the current command
  logic [conv_pkg::pix_w-1:0] ref_rows [3][conv_pkg::reg_bytes];

  conv_row_top dut (
    .clk, .reset, .img_we, .img_row, .img_seg, .img_data,
    .cmd_start, .cmd_row, .cmd_seg, .cmd_west_pad, .cmd_east_pad,
    .busy, .win_valid, .win_pixels, .row_end
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("watchdog expired, the commands did not all finish in time");
  end

  ////////////////////////////////////////
  // error handling and compares
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_window(input logic [win_bits-1:0] got, input logic [win_bits-1:0] exp,
                              input string name);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH time %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input logic [conv_pkg::idx_w-1:0] got,
                             input logic [conv_pkg::idx_w-1:0] exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH time %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // carried pixels, none for the first segment
  function automatic logic [conv_pkg::idx_w-1:0] slab_count(input logic [conv_pkg::seg_w-1:0] seg);
    return (seg == '0) ? '0 : conv_pkg::idx_w'(conv_pkg::slab_max);
  endfunction

  // slab, west zeros, 32 pixels, then zeros to the end
  task automatic build_reference(input int row, input int seg, input int west);
    int rr;
    int pos;
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < conv_pkg::reg_bytes; i++) begin
        ref_rows[r][i] = '0;
      end
      rr = row + r - 1;
      // rows off the image stay zero
      if (rr >= 0 && rr < conv_pkg::img_rows) begin
        pos = 0;
        if (seg != 0) begin
          ref_rows[r][0] = img_mem[rr][seg-1][conv_pkg::seg_pixels-2];
          ref_rows[r][1] = img_mem[rr][seg-1][conv_pkg::seg_pixels-1];
          pos = conv_pkg::slab_max;
        end
        pos = pos + west;
        for (int p = 0; p < conv_pkg::seg_pixels; p++) begin
          ref_rows[r][pos+p] = img_mem[rr][seg][p];
        end
      end
    end
  endtask

  // top row in the low bytes, left pixel first
  function automatic logic [win_bits-1:0] expected_window(input int k);
    logic [win_bits-1:0] w;
    w = '0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        w[(r*3+c)*conv_pkg::pix_w +: conv_pkg::pix_w] = ref_rows[r][k+c];
      end
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic load_image();
    logic [row_bits-1:0] word;
    integer rnd;
    for (int r = 0; r < conv_pkg::img_rows; r++) begin
      for (int s = 0; s < conv_pkg::img_segs; s++) begin
        for (int p = 0; p < conv_pkg::seg_pixels; p++) begin
          rnd = $random(seed);
          img_mem[r][s][p] = rnd[conv_pkg::pix_w-1:0];
          word[p*conv_pkg::pix_w +: conv_pkg::pix_w] = img_mem[r][s][p];
        end
        @(posedge clk);
        img_we <= 1'b1;
        img_row <= r[conv_pkg::row_w-1:0];
        img_seg <= s[conv_pkg::seg_w-1:0];
        img_data <= word;
      end
    end
    @(posedge clk);
    img_we <= 1'b0;
  endtask

  task automatic run_case(input int c);
    logic [conv_pkg::row_w-1:0] row;
    logic [conv_pkg::seg_w-1:0] seg;
    logic [conv_pkg::pad_w-1:0] west;
    logic [conv_pkg::pad_w-1:0] east;
    logic poke;
    logic [conv_pkg::idx_w-1:0] fill;
    logic [conv_pkg::idx_w-1:0] nwin;
    int k;
    logic done;
    row = case_tab[c][19:16];
    seg = case_tab[c][12];
    west = case_tab[c][11:8];
    east = case_tab[c][7:4];
    poke = case_tab[c][0];
    build_reference(row, seg, west);
    fill = slab_count(seg) + west + conv_pkg::seg_len + east;
    nwin = fill - 2;
    @(posedge clk);
    cmd_start <= 1'b1;
    cmd_row <= row;
    cmd_seg <= seg;
    cmd_west_pad <= west;
    cmd_east_pad <= east;
    // this edge samples the command
    @(posedge clk);
    cmd_start <= 1'b0;
    // fetch and reference block, no window yet
    for (int n = 0; n <= 5; n++) begin
      @(negedge clk);
      check_flag(win_valid, 1'b0, "win_valid");
      check_flag(row_end, 1'b0, "row_end");
      check_flag(busy, n != 0, "busy");
    end
    k = 0;
    done = 1'b0;
    // the first row_end ends the walk, so the count pins it to the last window
    while (!done) begin
      @(posedge clk);
      // a different command mid stream, expected to be dropped
      if (poke && k == 3) begin
        cmd_start <= 1'b1;
        cmd_row <= row + 4'd7;
        cmd_seg <= ~seg;
        cmd_west_pad <= 4'd1;
        cmd_east_pad <= 4'd2;
      end else begin
        cmd_start <= 1'b0;
      end
      @(negedge clk);
      check_flag(win_valid, 1'b1, "win_valid");
      check_flag(busy, 1'b1, "busy");
      if (row == '0) begin
        check_flag(win_pixels[3*conv_pkg::pix_w-1:0] == '0, 1'b1, "win_pixels top row");
      end
      if (row == conv_pkg::last_row) begin
        check_flag(win_pixels[win_bits-1 -: 3*conv_pkg::pix_w] == '0, 1'b1,
                   "win_pixels bottom row");
      end
      check_window(win_pixels, expected_window(k), "win_pixels");
      done = row_end;
      k++;
    end
    check_count(k[conv_pkg::idx_w-1:0], nwin, "window count");
    // busy drops on the edge after row_end
    @(negedge clk);
    check_flag(busy, 1'b0, "busy");
    check_flag(win_valid, 1'b0, "win_valid");
    check_flag(row_end, 1'b0, "row_end");
    if (poke) begin
      repeat (2) begin
        @(negedge clk);
        check_flag(busy, 1'b0, "busy");
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    img_we = 1'b0;
    img_row = '0;
    img_seg = '0;
    img_data = '0;
    cmd_start = 1'b0;
    cmd_row = '0;
    cmd_seg = '0;
    cmd_west_pad = '0;
    cmd_east_pad = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    // idle outputs straight out of reset
    check_flag(busy, 1'b0, "busy");
    check_flag(win_valid, 1'b0, "win_valid");
    check_flag(row_end, 1'b0, "row_end");
    load_image();
    for (int c = 0; c < num_cases; c++) begin
      run_case(c);
    end
    $display("Test OK");
    $finish;
  end

endmodule
